//--- hdl/brisc_cfg.svh
`ifndef BRISC_CFG_SVH
`define BRISC_CFG_SVH

// data and address word width
`define BRISC_XLEN 32
// register index width, 32 architectural registers
`define BRISC_REG_BITS 5
// unified memory depth in 32-bit words
`define BRISC_MEM_WORDS 256

`endif

//--- hdl/brisc_pkg.sv
`default_nettype none
`include "brisc_cfg.svh"

package brisc_pkg;

    typedef enum logic [1:0] {NONE, FROM_C, FROM_WB} fwd_src_e;
    typedef enum logic {FROM_ALU, FROM_CACHE} result_src_e;
    typedef enum logic {PC_PLUS4, FROM_EX} pc_src_e;
    typedef enum logic [2:0] {ADD, SUB, AND, OR, SLT} alu_op_e;

    typedef struct packed {
        logic [6:0]                 funct7;
        logic [`BRISC_REG_BITS-1:0] rs2;
        logic [`BRISC_REG_BITS-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`BRISC_REG_BITS-1:0] rd;
        logic [6:0]                 opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]                imm;
        logic [`BRISC_REG_BITS-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`BRISC_REG_BITS-1:0] rd;
        logic [6:0]                 opcode;
    } i_fmt_t;

    // beq shares this layout, its immediate bits are shuffled in decode
    typedef struct packed {
        logic [6:0]                 imm_hi;
        logic [`BRISC_REG_BITS-1:0] rs2;
        logic [`BRISC_REG_BITS-1:0] rs1;
        logic [2:0]                 funct3;
        logic [4:0]                 imm_lo;
        logic [6:0]                 opcode;
    } s_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
    } instr_u;

    typedef struct packed {
        logic                   valid;
        logic [`BRISC_XLEN-1:0] pc;
        logic [`BRISC_XLEN-1:0] instr;
    } fd_reg_t;

    typedef struct packed {
        logic                       valid;
        logic [`BRISC_XLEN-1:0]     pc;
        logic [`BRISC_REG_BITS-1:0] rs1;
        logic [`BRISC_REG_BITS-1:0] rs2;
        logic [`BRISC_REG_BITS-1:0] rd;
        logic [`BRISC_XLEN-1:0]     rs1_val;
        logic [`BRISC_XLEN-1:0]     rs2_val;
        logic [`BRISC_XLEN-1:0]     imm;
        alu_op_e                    alu_op;
        logic                       use_imm;
        logic                       reg_write;
        logic                       mem_write;
        logic                       is_branch;
        result_src_e                result_src;
    } dex_reg_t;

    typedef struct packed {
        logic                       valid;
        logic [`BRISC_REG_BITS-1:0] rd;
        logic [`BRISC_XLEN-1:0]     alu_result;
        logic [`BRISC_XLEN-1:0]     store_data;
        logic                       reg_write;
        logic                       mem_write;
        result_src_e                result_src;
    } exc_reg_t;

    typedef struct packed {
        logic                       valid;
        logic [`BRISC_REG_BITS-1:0] rd;
        logic [`BRISC_XLEN-1:0]     result;
        logic                       reg_write;
    } cwb_reg_t;

    typedef struct packed {
        logic                   valid;
        logic                   write;
        logic [`BRISC_XLEN-1:0] addr;
        logic [`BRISC_XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [`BRISC_REG_BITS-1:0] rd;
        logic [`BRISC_XLEN-1:0]     data;
    } retire_t;

endpackage

`default_nettype wire

//--- hdl/hazard.sv
`default_nettype none
`include "brisc_cfg.svh"

module hazard
    import brisc_pkg::*;
(
    input  logic [`BRISC_REG_BITS-1:0] rs1_EX,
    input  logic [`BRISC_REG_BITS-1:0] rs2_EX,
    input  logic [`BRISC_REG_BITS-1:0] rs1_D,
    input  logic [`BRISC_REG_BITS-1:0] rs2_D,
    input  logic [`BRISC_REG_BITS-1:0] rd_EX,
    input  logic [`BRISC_REG_BITS-1:0] rd_C,
    input  logic [`BRISC_REG_BITS-1:0] rd_WB,
    input  logic                       reg_write_C,
    input  logic                       reg_write_WB,
    input  result_src_e                result_src_EX,
    input  pc_src_e                    pc_src,
    output fwd_src_e                   fwd_src1,
    output fwd_src_e                   fwd_src2,
    output logic                       stall_F,
    output logic                       stall_D,
    output logic                       flush_D,
    output logic                       flush_EX
);

    logic load_stall;
    logic pc_taken;

    // the younger producer in C shadows an older one in WB
    function automatic fwd_src_e pick_src(input logic [`BRISC_REG_BITS-1:0] rs);
        if (rs != '0 && reg_write_C && rs == rd_C) begin
            return FROM_C;
        end
        if (rs != '0 && reg_write_WB && rs == rd_WB) begin
            return FROM_WB;
        end
        return NONE;
    endfunction

    always_comb begin
        fwd_src1 = pick_src(rs1_EX);
        fwd_src2 = pick_src(rs2_EX);
    end

    // a load in EX cannot feed the instruction right behind it
    assign load_stall = (result_src_EX == FROM_CACHE) && (rs1_D == rd_EX || rs2_D == rd_EX);
    assign pc_taken   = (pc_src == FROM_EX);

    assign stall_F  = load_stall;
    assign stall_D  = load_stall;
    assign flush_D  = pc_taken;
    assign flush_EX = load_stall || pc_taken;

    always_comb begin
        assert final (stall_F == stall_D);
        assert final (!stall_F || flush_EX);
    end

endmodule

`default_nettype wire

//--- hdl/fetch.sv
`default_nettype none
`include "brisc_cfg.svh"

module fetch
    import brisc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    input  logic                   stall_F,
    input  logic                   stall_D,
    input  logic                   flush_D,
    input  pc_src_e                pc_src,
    input  logic [`BRISC_XLEN-1:0] branch_target,
    output mem_req_t               fetch_req,
    input  logic                   fetch_grant,
    input  logic [`BRISC_XLEN-1:0] rdata,
    output fd_reg_t                fd
);

    logic [`BRISC_XLEN-1:0] pc;

    assign fetch_req = '{valid: run && !stall_F, write: 1'b0, addr: pc, wdata: '0};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pc_src == FROM_EX) begin
            pc <= branch_target;
        end else if (!stall_F && fetch_grant) begin
            pc <= pc + `BRISC_XLEN'd4;
        end
    end

    // a lost grant or a redirect leaves a bubble in D
    always_ff @(posedge clk) begin
        if (rst || flush_D) begin
            fd <= '0;
        end else if (!stall_D) begin
            if (fetch_grant) begin
                fd <= '{valid: 1'b1, pc: pc, instr: rdata};
            end else begin
                fd <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/decode.sv
`default_nettype none
`include "brisc_cfg.svh"

module decode
    import brisc_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  fd_reg_t                    fd,
    input  logic                       flush_EX,
    input  cwb_reg_t                   wb,
    output logic [`BRISC_REG_BITS-1:0] rs1_D,
    output logic [`BRISC_REG_BITS-1:0] rs2_D,
    output dex_reg_t                   dex
);

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    instr_u                 ir;
    logic [`BRISC_XLEN-1:0] regs [2**`BRISC_REG_BITS];
    logic                   wb_we;
    logic [`BRISC_XLEN-1:0] imm_i;
    logic [`BRISC_XLEN-1:0] imm_s;
    logic [`BRISC_XLEN-1:0] imm_b;
    dex_reg_t               nxt;

    assign ir    = fd.instr;
    assign rs1_D = ir.r.rs1;
    assign rs2_D = ir.r.rs2;
    assign wb_we = wb.valid && wb.reg_write && wb.rd != '0;

    assign imm_i = {{(`BRISC_XLEN-12){ir.i.imm[11]}}, ir.i.imm};
    assign imm_s = {{(`BRISC_XLEN-12){ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
    assign imm_b = {{(`BRISC_XLEN-12){ir.s.imm_hi[6]}}, ir.s.imm_lo[0],
                    ir.s.imm_hi[5:0], ir.s.imm_lo[4:1], 1'b0};

    // the value written at this edge is already visible to decode
    function automatic logic [`BRISC_XLEN-1:0] read_reg(
        input logic [`BRISC_REG_BITS-1:0] idx
    );
        if (wb_we && wb.rd == idx) begin
            return wb.result;
        end
        return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            regs[0] <= '0;
        end else if (wb_we) begin
            regs[wb.rd] <= wb.result;
        end
    end

    always_comb begin
        nxt         = '0;
        nxt.valid   = fd.valid;
        nxt.pc      = fd.pc;
        nxt.rs1     = rs1_D;
        nxt.rs2     = rs2_D;
        nxt.rd      = ir.r.rd;
        nxt.rs1_val = read_reg(rs1_D);
        nxt.rs2_val = read_reg(rs2_D);
        if (fd.valid) begin
            case (ir.r.opcode)
                OP_REG: begin
                    nxt.reg_write = 1'b1;
                    case (ir.r.funct3)
                        3'b000:  nxt.alu_op = ir.r.funct7[5] ? SUB : ADD;
                        3'b010:  nxt.alu_op = SLT;
                        3'b110:  nxt.alu_op = OR;
                        3'b111:  nxt.alu_op = AND;
                        default: nxt.reg_write = 1'b0;
                    endcase
                end
                OP_IMM, OP_LOAD: begin
                    nxt.imm       = imm_i;
                    nxt.use_imm   = 1'b1;
                    nxt.reg_write = 1'b1;
                    nxt.result_src = (ir.r.opcode == OP_LOAD) ? FROM_CACHE : FROM_ALU;
                end
                OP_STORE: begin
                    nxt.imm       = imm_s;
                    nxt.use_imm   = 1'b1;
                    nxt.mem_write = 1'b1;
                end
                OP_BRANCH: begin
                    nxt.imm       = imm_b;
                    nxt.is_branch = 1'b1;
                end
                // unknown opcodes pass through as a nop
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush_EX) begin
            dex <= '0;
        end else begin
            dex <= nxt;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (wb.valid && wb.reg_write && wb.rd == '0) |=> regs[0] == '0);

endmodule

`default_nettype wire

//--- hdl/execute.sv
`default_nettype none
`include "brisc_cfg.svh"

module execute
    import brisc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  dex_reg_t               dex,
    input  fwd_src_e               fwd_src1,
    input  fwd_src_e               fwd_src2,
    input  logic [`BRISC_XLEN-1:0] c_value,
    input  logic [`BRISC_XLEN-1:0] wb_value,
    output pc_src_e                pc_src,
    output logic [`BRISC_XLEN-1:0] branch_target,
    output exc_reg_t               exc
);

    logic [`BRISC_XLEN-1:0] src1;
    logic [`BRISC_XLEN-1:0] src2;
    logic [`BRISC_XLEN-1:0] op2;
    logic [`BRISC_XLEN-1:0] alu_y;

    always_comb begin
        case (fwd_src1)
            FROM_C:  src1 = c_value;
            FROM_WB: src1 = wb_value;
            default: src1 = dex.rs1_val;
        endcase
        case (fwd_src2)
            FROM_C:  src2 = c_value;
            FROM_WB: src2 = wb_value;
            default: src2 = dex.rs2_val;
        endcase
    end

    assign op2 = dex.use_imm ? dex.imm : src2;

    always_comb begin
        case (dex.alu_op)
            SUB:     alu_y = src1 - op2;
            AND:     alu_y = src1 & op2;
            OR:      alu_y = src1 | op2;
            SLT:     alu_y = {{(`BRISC_XLEN-1){1'b0}}, $signed(src1) < $signed(op2)};
            default: alu_y = src1 + op2;
        endcase
    end

    // beq is the only redirect, resolved here
    assign pc_src        = (dex.valid && dex.is_branch && src1 == src2) ? FROM_EX : PC_PLUS4;
    assign branch_target = dex.pc + dex.imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            exc <= '0;
        end else begin
            exc <= '{valid: dex.valid, rd: dex.rd, alu_result: alu_y, store_data: src2,
                     reg_write: dex.reg_write, mem_write: dex.mem_write,
                     result_src: dex.result_src};
        end
    end

endmodule

`default_nettype wire

//--- hdl/cache_stage.sv
`default_nettype none
`include "brisc_cfg.svh"

module cache_stage
    import brisc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  exc_reg_t               exc,
    output mem_req_t               data_req,
    input  logic                   data_grant,
    input  logic [`BRISC_XLEN-1:0] rdata,
    output cwb_reg_t               wb,
    output logic [`BRISC_XLEN-1:0] wb_value,
    output logic                   retire_valid,
    output retire_t                retire
);

    logic [`BRISC_XLEN-1:0] result;

    assign data_req = '{valid: exc.valid && (exc.mem_write || exc.result_src == FROM_CACHE),
                        write: exc.mem_write, addr: exc.alu_result, wdata: exc.store_data};

    assign result = (exc.result_src == FROM_CACHE) ? rdata : exc.alu_result;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb <= '0;
        end else begin
            wb <= '{valid: exc.valid, rd: exc.rd, result: result, reg_write: exc.reg_write};
        end
    end

    assign wb_value     = wb.result;
    assign retire_valid = wb.valid && wb.reg_write && wb.rd != '0;
    assign retire       = '{rd: wb.rd, data: wb.result};

    // data accesses never wait, only the loader can take the memory from C
    assert property (@(posedge clk) disable iff (rst) data_req.valid |-> data_grant);

endmodule

`default_nettype wire

//--- hdl/mem_arbiter.sv
`default_nettype none
`include "brisc_cfg.svh"

module mem_arbiter
    import brisc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  mem_req_t               load,
    output logic                   load_ready,
    input  mem_req_t               data_req,
    input  mem_req_t               fetch_req,
    output logic                   data_grant,
    output logic                   fetch_grant,
    output logic [`BRISC_XLEN-1:0] rdata
);

    localparam int ADDR_BITS = $clog2(`BRISC_MEM_WORDS);

    logic [`BRISC_XLEN-1:0] mem [`BRISC_MEM_WORDS];
    mem_req_t               sel;
    logic                   load_grant;
    logic [ADDR_BITS-1:0]   idx;

    // loader has top priority, so it is never turned away
    assign load_ready  = 1'b1;
    assign load_grant  = load.valid && load_ready;
    assign data_grant  = data_req.valid && !load_grant;
    assign fetch_grant = fetch_req.valid && !load_grant && !data_req.valid;

    always_comb begin
        if (load_grant) begin
            sel = load;
        end else if (data_req.valid) begin
            sel = data_req;
        end else begin
            sel = fetch_req;
        end
    end

    // word addressed, byte offset bits are ignored
    assign idx   = sel.addr[ADDR_BITS+1:2];
    assign rdata = mem[idx];

    always_ff @(posedge clk) begin
        if (!rst && sel.valid && sel.write) begin
            mem[idx] <= sel.wdata;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        $onehot0({load_grant, data_grant, fetch_grant}));

endmodule

`default_nettype wire

//--- hdl/brisc_core.sv
`default_nettype none
`include "brisc_cfg.svh"

module brisc_core
    import brisc_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     run,
    input  mem_req_t load,
    output logic     load_ready,
    output logic     retire_valid,
    output retire_t  retire
);

    fd_reg_t                    fd;
    dex_reg_t                   dex;
    exc_reg_t                   exc;
    cwb_reg_t                   wb;
    logic [`BRISC_REG_BITS-1:0] rs1_D;
    logic [`BRISC_REG_BITS-1:0] rs2_D;
    fwd_src_e                   fwd_src1;
    fwd_src_e                   fwd_src2;
    logic                       stall_F;
    logic                       stall_D;
    logic                       flush_D;
    logic                       flush_EX;
    pc_src_e                    pc_src;
    logic [`BRISC_XLEN-1:0]     branch_target;
    logic [`BRISC_XLEN-1:0]     wb_value;
    logic [`BRISC_XLEN-1:0]     rdata;
    mem_req_t                   fetch_req;
    mem_req_t                   data_req;
    logic                       fetch_grant;
    logic                       data_grant;

    fetch u_fetch (
        .clk(clk), .rst(rst), .run(run),
        .stall_F(stall_F), .stall_D(stall_D), .flush_D(flush_D),
        .pc_src(pc_src), .branch_target(branch_target),
        .fetch_req(fetch_req), .fetch_grant(fetch_grant), .rdata(rdata), .fd(fd)
    );

    decode u_decode (
        .clk(clk), .rst(rst), .fd(fd), .flush_EX(flush_EX), .wb(wb),
        .rs1_D(rs1_D), .rs2_D(rs2_D), .dex(dex)
    );

    execute u_execute (
        .clk(clk), .rst(rst), .dex(dex), .fwd_src1(fwd_src1), .fwd_src2(fwd_src2),
        .c_value(exc.alu_result), .wb_value(wb_value),
        .pc_src(pc_src), .branch_target(branch_target), .exc(exc)
    );

    cache_stage u_cache (
        .clk(clk), .rst(rst), .exc(exc),
        .data_req(data_req), .data_grant(data_grant), .rdata(rdata),
        .wb(wb), .wb_value(wb_value), .retire_valid(retire_valid), .retire(retire)
    );

    hazard u_hazard (
        .rs1_EX(dex.rs1), .rs2_EX(dex.rs2), .rs1_D(rs1_D), .rs2_D(rs2_D),
        .rd_EX(dex.rd), .rd_C(exc.rd), .rd_WB(wb.rd),
        .reg_write_C(exc.reg_write), .reg_write_WB(wb.reg_write),
        .result_src_EX(dex.result_src), .pc_src(pc_src),
        .fwd_src1(fwd_src1), .fwd_src2(fwd_src2),
        .stall_F(stall_F), .stall_D(stall_D), .flush_D(flush_D), .flush_EX(flush_EX)
    );

    mem_arbiter u_arbiter (
        .clk(clk), .rst(rst), .load(load), .load_ready(load_ready),
        .data_req(data_req), .fetch_req(fetch_req),
        .data_grant(data_grant), .fetch_grant(fetch_grant), .rdata(rdata)
    );

endmodule

`default_nettype wire

//--- tb/tb_ref_model.svh
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// data region of the unified memory, word index and size
localparam int DATA_WORD0 = 128;
localparam int DATA_WORDS = 16;

logic [31:0] lfsr_state = 32'd79723;
logic [31:0] ref_regs [32] = '{default: '0};
logic [31:0] ref_mem [`BRISC_MEM_WORDS];

function automatic logic [31:0] alu_rr(input alu_op_e op, input int rd, input int rs1,
                                       input int rs2);
    logic [9:0] f;
    case (op)
        SUB:     f = {7'h20, 3'b000};
        AND:     f = {7'h00, 3'b111};
        OR:      f = {7'h00, 3'b110};
        SLT:     f = {7'h00, 3'b010};
        default: f = {7'h00, 3'b000};
    endcase
    return {f[9:3], rs2[4:0], rs1[4:0], f[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
endfunction

function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
endfunction

function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] beq(input int rs1, input int rs2, input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], 7'b1100011};
endfunction

// fill value mixes every bit of the word address
function automatic logic [31:0] data_fill(input int word);
    return (32'(word) * 32'h9E37_79B9) ^ 32'h00C3_A5F0;
endfunction

// galois form, taps of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
        v = {v[30:0], lfsr_state[0]};
        lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
endfunction

// in-order ISA interpretation up to the halting beq x0,x0,0
function automatic void interpret();
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] y;
    logic [31:0] addr;
    logic        wr;
    int          steps;
    pc = '0;
    steps = 0;
    w = prog[0];
    while (w != beq(0, 0, 0) && steps < 1000) begin
        a = ref_regs[w[19:15]];
        b = ref_regs[w[24:20]];
        y = {{20{w[31]}}, w[31:20]};
        addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
        wr = 1'b1;
        pc = pc + 4;
        case (w[6:0])
            7'b0110011: begin
                case ({w[30], w[14:12]})
                    4'b1000: y = a - b;
                    4'b0111: y = a & b;
                    4'b0110: y = a | b;
                    4'b0010: y = {31'b0, $signed(a) < $signed(b)};
                    default: y = a + b;
                endcase
            end
            7'b0010011: y = a + y;
            7'b0000011: y = ref_mem[((a + y) >> 2) % `BRISC_MEM_WORDS];
            7'b0100011: begin
                ref_mem[(addr >> 2) % `BRISC_MEM_WORDS] = b;
                wr = 1'b0;
            end
            7'b1100011: begin
                if (a == b) begin
                    pc = pc - 4 + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
                end
                wr = 1'b0;
            end
            default: wr = 1'b0;
        endcase
        if (wr && w[11:7] != 0) begin
            ref_regs[w[11:7]] = y;
            expected.push_back('{rd: w[11:7], data: y});
        end
        w = prog[pc[31:2]];
        steps++;
    end
endfunction

`endif

//--- tb/tb_brisc.sv
`default_nettype none
`include "brisc_cfg.svh"

module tb_brisc
    import brisc_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int SETTLE_CYCLES = 8;
    localparam int IDLE_CYCLES = 40;

    logic        clk;
    logic        rst;
    logic        run;
    mem_req_t    load;
    logic        load_ready;
    logic        retire_valid;
    retire_t     retire;

    logic [31:0] prog [$];
    retire_t     expected [$];
    int          retire_count = 0;
    int          cycles = 0;
    int          cycle_limit = 0;

    `include "tb_ref_model.svh"

    brisc_core i_dut (
        .clk(clk), .rst(rst), .run(run), .load(load), .load_ready(load_ready),
        .retire_valid(retire_valid), .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Error at %0t: retired x%0d = %h, expected x%0d = %h",
                                     $time, got.rd, got.data, exp.rd, exp.data));
        end
    endtask

    task automatic check_count(input int got, input int exp);
        if (got !== exp) begin
            report_failure($sformatf("Error at %0t: %0d writes retired, expected %0d",
                                     $time, got, exp));
        end
    endtask

    // retire outputs change just after the rising edge
    always @(negedge clk) begin
        if (!rst && retire_valid) begin
            if (expected.size() == 0) begin
                report_failure("the core retired a register write that the program never makes");
            end else begin
                check_retire(retire, expected.pop_front());
                retire_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            report_failure("timeout: the tests did not finish within the cycle limit");
        end
    end

    task automatic apply_reset();
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;
    endtask

    task automatic write_mem(input int word, input logic [31:0] data);
        load = '{valid: 1'b1, write: 1'b1, addr: 32'(word) << 2, wdata: data};
        @(negedge clk);
        while (!load_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #10;
    endtask

    task automatic run_program(input string name);
        int total;
        int last_count;
        int idle;
        cycle_limit += 6 * prog.size() + 40;
        for (int k = 0; k < DATA_WORDS; k++) begin
            ref_mem[DATA_WORD0 + k] = data_fill(DATA_WORD0 + k);
        end
        interpret();
        total = expected.size();
        apply_reset();
        foreach (prog[k]) begin
            write_mem(k, prog[k]);
        end
        // two words past the halt are fetched before the redirect
        write_mem(prog.size(), addi(0, 0, 0));
        write_mem(prog.size() + 1, addi(0, 0, 0));
        for (int k = 0; k < DATA_WORDS; k++) begin
            write_mem(DATA_WORD0 + k, data_fill(DATA_WORD0 + k));
        end
        load = '0;
        retire_count = 0;
        run = 1'b1;
        last_count = 0;
        idle = 0;
        // stop waiting once the core has gone quiet
        while (expected.size() != 0 && idle < IDLE_CYCLES) begin
            @(posedge clk);
            if (retire_count != last_count) begin
                last_count = retire_count;
                idle = 0;
            end else begin
                idle++;
            end
        end
        repeat (SETTLE_CYCLES) @(posedge clk);
        #10;
        check_count(retire_count, total);
        run = 1'b0;
        $display("%s: %0d register writes retired", name, retire_count);
    endtask

    task automatic forwarding_program();
        prog.delete();
        for (int r = 1; r < 8; r++) begin
            prog.push_back(addi(r, 0, r * 3 - 5));
        end
        prog.push_back(alu_rr(ADD, 1, 1, 2));
        prog.push_back(alu_rr(SUB, 3, 1, 2));
        prog.push_back(alu_rr(OR, 4, 3, 1));
        prog.push_back(alu_rr(AND, 5, 4, 3));
        prog.push_back(alu_rr(SLT, 6, 5, 4));
        prog.push_back(alu_rr(SLT, 7, 4, 1));
        prog.push_back(beq(0, 0, 0));
    endtask

    task automatic x0_program();
        prog.delete();
        prog.push_back(addi(0, 0, 99));
        prog.push_back(alu_rr(ADD, 1, 0, 0));
        prog.push_back(addi(0, 2, 5));
        prog.push_back(alu_rr(OR, 2, 0, 2));
        prog.push_back(alu_rr(ADD, 0, 1, 2));
        prog.push_back(alu_rr(SUB, 3, 0, 2));
        prog.push_back(beq(0, 0, 0));
    endtask

    task automatic load_use_program();
        prog.delete();
        prog.push_back(lw(1, 0, 512));
        prog.push_back(alu_rr(ADD, 2, 1, 1));
        prog.push_back(lw(3, 0, 516));
        prog.push_back(addi(4, 0, 1));
        prog.push_back(alu_rr(SUB, 5, 3, 4));
        prog.push_back(lw(6, 0, 520));
        prog.push_back(sw(6, 0, 524));
        prog.push_back(lw(7, 0, 524));
        prog.push_back(beq(0, 0, 0));
    endtask

    task automatic branch_program();
        prog.delete();
        prog.push_back(addi(1, 0, 4));
        prog.push_back(addi(2, 0, 4));
        // taken branch skips the next two
        prog.push_back(beq(1, 2, 12));
        prog.push_back(addi(3, 0, 111));
        prog.push_back(addi(4, 0, 222));
        prog.push_back(addi(5, 0, 33));
        prog.push_back(beq(1, 5, 8));
        prog.push_back(addi(6, 5, 1));
        prog.push_back(beq(0, 0, 0));
    endtask

    task automatic store_load_program();
        prog.delete();
        prog.push_back(addi(3, 0, 77));
        prog.push_back(sw(3, 0, 528));
        prog.push_back(lw(4, 0, 528));
        prog.push_back(alu_rr(ADD, 5, 4, 3));
        prog.push_back(sw(5, 0, 532));
        prog.push_back(addi(6, 0, 9));
        prog.push_back(lw(7, 0, 532));
        prog.push_back(alu_rr(OR, 1, 7, 6));
        prog.push_back(beq(0, 0, 0));
    endtask

    // loads and stores use x0 as base so they stay in the data region
    task automatic random_program(input int count);
        int kind;
        int rd;
        int rs1;
        int rs2;
        prog.delete();
        for (int n = 0; n < count; n++) begin
            kind = take_bits(3);
            rd = take_bits(3);
            rs1 = take_bits(3);
            rs2 = take_bits(3);
            case (kind)
                5: prog.push_back(addi(rd, rs1, int'(take_bits(5)) - 16));
                6: prog.push_back(lw(rd, 0, 4 * (DATA_WORD0 + take_bits(4))));
                7: prog.push_back(sw(rs2, 0, 4 * (DATA_WORD0 + take_bits(4))));
                default: prog.push_back(alu_rr(alu_op_e'(kind), rd, rs1, rs2));
            endcase
        end
        prog.push_back(beq(0, 0, 0));
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 10);
        rst = 1'b1;
        run = 1'b0;
        load = '0;
        // the first program also sets x1 to x7 for the later ones
        forwarding_program();
        run_program("forwarding");
        x0_program();
        run_program("x0 handling");
        load_use_program();
        run_program("load-use");
        branch_program();
        run_program("branch");
        store_load_program();
        run_program("store and load");
        random_program(40);
        run_program("random");
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+hdl
+incdir+tb
hdl/brisc_pkg.sv
hdl/hazard.sv
hdl/fetch.sv
hdl/decode.sv
hdl/execute.sv
hdl/cache_stage.sv
hdl/mem_arbiter.sv
hdl/brisc_core.sv
tb/tb_brisc.sv
